// File: xmen_pkg.sv
// ###########################################################################
// Shared definitions for the game board slice
//  - memory map of the main CPU bus and sound latch offsets
//  - region and bus responder state enums
//  - APB request, decoded peripheral request and sound bus structs
// ###########################################################################
package xmen_pkg;

    // Memory sizes in words
    localparam int OBJ_AW = 13;
    localparam int PAL_AW = 8;

    // Region bases, only bits 16:14 take part in the decode
    localparam logic [16:0] OBJ_BASE = 17'h00000;
    localparam logic [16:0] PAL_BASE = 17'h04000;
    localparam logic [16:0] SND_BASE = 17'h08000;

    // Word offsets inside the sound region
    localparam logic [3:0] SND_CMD   = 4'd0;
    localparam logic [3:0] SND_PAIR  = 4'd1;
    localparam logic [3:0] SND_REPLY = 4'd2;
    localparam logic [3:0] SND_MUTE  = 4'd3;

    // Pixel index to colour latency
    localparam int PAL_LAT = 2;

    typedef enum logic [1:0] {REG_OBJ, REG_PAL, REG_SND, REG_NONE} region_e;

    typedef enum logic [1:0] {IDLE, WAIT, DONE} bus_state_e;

    typedef struct packed {
        logic [16:0] paddr;
        logic        pwrite;
        logic [15:0] pwdata;
        logic [1:0]  pstrb;
    } apb_req_t;

    typedef struct packed {
        logic [12:0] addr;
        logic [15:0] din;
        logic [1:0]  we;
    } cpu_bus_t;

    typedef struct packed {
        logic [3:0] addr;
        logic       rd;
        logic       wr;
        logic [7:0] din;
    } snd_bus_t;

endpackage

// File: xmen_main_bus.sv
// ###########################################################################
// Main CPU bus decoder
//  - APB slave with a fixed single wait state
//  - region decode into object RAM, palette and sound selects
//  - error response for unmapped addresses, read data mux
// ###########################################################################
`timescale 1ns/1ps

module xmen_main_bus (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  xmen_pkg::apb_req_t req,
    output logic [15:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output xmen_pkg::cpu_bus_t bus,
    output logic               obj_cs,
    output logic               pal_cs,
    output logic               snd_cs,
    input  logic [15:0]        obj_dout,
    input  logic [15:0]        pal_dout,
    input  logic [7:0]         snd_dout_main
);
    import xmen_pkg::*;

    bus_state_e state;
    region_e    region;
    region_e    region_q;
    logic       access;

    // Region from the top address bits
    always_comb begin
        case (req.paddr[16:14])
            OBJ_BASE[16:14]: region = REG_OBJ;
            PAL_BASE[16:14]: region = REG_PAL;
            SND_BASE[16:14]: region = REG_SND;
            default:         region = REG_NONE;
        endcase
    end

    // First access cycle, the one that reaches the peripherals
    assign access = (state == WAIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            region_q <= REG_NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (psel && !penable) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    // Master dropped the transfer, go back quietly
                    state    <= psel ? DONE : IDLE;
                    region_q <= region;
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Peripheral request, valid while selected
    assign bus.addr = req.paddr[13:1];
    assign bus.din  = req.pwdata;
    assign bus.we   = (access && req.pwrite) ? req.pstrb : 2'b00;

    assign obj_cs = access && (region == REG_OBJ);
    assign pal_cs = access && (region == REG_PAL);
    assign snd_cs = access && (region == REG_SND);

    assign pready  = (state == DONE);
    assign pslverr = (state == DONE) && (region_q == REG_NONE);

    // Peripherals registered their data at the end of WAIT
    always_comb begin
        prdata = 16'h0000;
        if (state == DONE) begin
            case (region_q)
                REG_OBJ: prdata = obj_dout;
                REG_PAL: prdata = pal_dout;
                REG_SND: prdata = {8'h00, snd_dout_main};
                default: prdata = 16'h0000;
            endcase
        end
    end

endmodule

// File: xmen_obj_ram.sv
// ###########################################################################
// Object RAM
//  - 8K x 16 words with byte lane writes from the main CPU
//  - CPU address rewired into the board's physical order
//  - second read port for the sprite scanner
// ###########################################################################
`timescale 1ns/1ps

module xmen_obj_ram (
    input  logic                          clk,
    input  xmen_pkg::cpu_bus_t            bus,
    input  logic                          cs,
    output logic [15:0]                   dout,
    input  logic [xmen_pkg::OBJ_AW-1:0]   scan_addr,
    output logic [15:0]                   scan_data
);
    import xmen_pkg::*;

    logic [15:0]       mem [0:(1<<OBJ_AW)-1];
    logic [13:1]       cpu_a;
    logic [OBJ_AW-1:0] phys_a;

    // Word address indexed with the CPU bit numbers
    assign cpu_a = bus.addr;

    // Board wiring: a6 a5 a1 then a13..a7, then a4..a2
    assign phys_a = {cpu_a[6:5], cpu_a[1], cpu_a[13:7], cpu_a[4:2]};

    // CPU port
    always_ff @(posedge clk) begin
        if (cs) begin
            if (bus.we[1]) begin
                mem[phys_a][15:8] <= bus.din[15:8];
            end
            if (bus.we[0]) begin
                mem[phys_a][7:0] <= bus.din[7:0];
            end
            dout <= mem[phys_a];
        end
    end

    // Scanner port works on physical addresses
    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];
    end

endmodule

// File: xmen_palette.sv
// ###########################################################################
// Palette RAM
//  - 256 entries of xRGB555 with byte lane writes from the main CPU
//  - two stage pixel lookup: entry read, then colour split
//  - blanked pixels leave as black
// ###########################################################################
`timescale 1ns/1ps

module xmen_palette (
    input  logic               clk,
    input  logic               rst_n,
    input  xmen_pkg::cpu_bus_t bus,
    input  logic               cs,
    output logic [15:0]        dout,
    input  logic [7:0]         pxl_idx,
    input  logic               blank,
    output logic [4:0]         red,
    output logic [4:0]         green,
    output logic [4:0]         blue
);
    import xmen_pkg::*;

    logic [15:0]       mem [0:(1<<PAL_AW)-1];
    logic [PAL_AW-1:0] cpu_a;
    logic [15:0]       pal_q;
    logic              blank_q;

    // Word address bits 8:1
    assign cpu_a = bus.addr[PAL_AW-1:0];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (bus.we[1]) begin
                mem[cpu_a][15:8] <= bus.din[15:8];
            end
            if (bus.we[0]) begin
                mem[cpu_a][7:0] <= bus.din[7:0];
            end
            dout <= mem[cpu_a];
        end
    end

    // Stage 1: fetch the entry, blank travels alongside
    always_ff @(posedge clk) begin
        pal_q   <= mem[pxl_idx];
        blank_q <= blank;
    end

    // Stage 2: split into colours
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red   <= 5'd0;
            green <= 5'd0;
            blue  <= 5'd0;
        end else if (blank_q) begin
            red   <= 5'd0;
            green <= 5'd0;
            blue  <= 5'd0;
        end else begin
            red   <= pal_q[14:10];
            green <= pal_q[9:5];
            blue  <= pal_q[4:0];
        end
    end

endmodule

// File: xmen_snd_comm.sv
// ###########################################################################
// Main to sound CPU communication
//  - command latch with sound interrupt, pair latch
//  - reply register written by the sound CPU
//  - mute bit
// ###########################################################################
`timescale 1ns/1ps

module xmen_snd_comm (
    input  logic               clk,
    input  logic               rst_n,
    input  xmen_pkg::cpu_bus_t bus,
    input  logic               cs,
    output logic [7:0]         dout_main,
    input  xmen_pkg::snd_bus_t snd,
    output logic [7:0]         snd_dout,
    output logic               snd_irq,
    output logic               mute
);
    import xmen_pkg::*;

    logic [7:0] cmd_latch;
    logic [7:0] pair_latch;
    logic [7:0] reply;
    logic [3:0] main_off;
    logic       main_wr;

    assign main_off = bus.addr[3:0];
    // Only the low byte is wired on this side
    assign main_wr  = cs && bus.we[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_latch  <= 8'h00;
            pair_latch <= 8'h00;
            reply      <= 8'h00;
            snd_irq    <= 1'b0;
            mute       <= 1'b0;
        end else begin
            // Sound CPU acknowledges by reading the command
            if (snd.rd && snd.addr == SND_CMD) begin
                snd_irq <= 1'b0;
            end
            if (main_wr) begin
                case (main_off)
                    SND_CMD: begin
                        cmd_latch <= bus.din[7:0];
                        snd_irq   <= 1'b1;
                    end
                    SND_PAIR: pair_latch <= bus.din[7:0];
                    SND_MUTE: mute       <= bus.din[0];
                    default: ;
                endcase
            end
            if (snd.wr && snd.addr == SND_REPLY) begin
                reply <= snd.din;
            end
        end
    end

    // Main CPU read, one cycle after select
    always_ff @(posedge clk) begin
        if (cs) begin
            dout_main <= (main_off == SND_REPLY) ? reply : 8'h00;
        end
    end

    always_comb begin
        case (snd.addr)
            SND_CMD:  snd_dout = cmd_latch;
            SND_PAIR: snd_dout = pair_latch;
            default:  snd_dout = 8'h00;
        endcase
    end

endmodule

// File: xmen_game.sv
// ###########################################################################
// Game board top level
//  - main bus decoder on APB
//  - object RAM, palette and sound communication peripherals
// ###########################################################################
`timescale 1ns/1ps

module xmen_game (
    input  logic                          clk,
    input  logic                          rst_n,
    // Main CPU bus
    input  logic                          psel,
    input  logic                          penable,
    input  xmen_pkg::apb_req_t            req,
    output logic [15:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    // Pixels
    input  logic [7:0]                    pxl_idx,
    input  logic                          blank,
    output logic [4:0]                    red,
    output logic [4:0]                    green,
    output logic [4:0]                    blue,
    // Sprite scanner
    input  logic [xmen_pkg::OBJ_AW-1:0]   scan_addr,
    output logic [15:0]                   scan_data,
    // Sound CPU
    input  xmen_pkg::snd_bus_t            snd,
    output logic [7:0]                    snd_dout,
    output logic                          snd_irq,
    output logic                          mute
);
    import xmen_pkg::*;

    cpu_bus_t    bus;
    logic        obj_cs;
    logic        pal_cs;
    logic        snd_cs;
    logic [15:0] obj_dout;
    logic [15:0] pal_dout;
    logic [7:0]  snd_dout_main;

    xmen_main_bus u_main_bus (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .psel          ( psel          ),
        .penable       ( penable       ),
        .req           ( req           ),
        .prdata        ( prdata        ),
        .pready        ( pready        ),
        .pslverr       ( pslverr       ),
        .bus           ( bus           ),
        .obj_cs        ( obj_cs        ),
        .pal_cs        ( pal_cs        ),
        .snd_cs        ( snd_cs        ),
        .obj_dout      ( obj_dout      ),
        .pal_dout      ( pal_dout      ),
        .snd_dout_main ( snd_dout_main )
    );

    xmen_obj_ram u_obj_ram (
        .clk       ( clk       ),
        .bus       ( bus       ),
        .cs        ( obj_cs    ),
        .dout      ( obj_dout  ),
        .scan_addr ( scan_addr ),
        .scan_data ( scan_data )
    );

    xmen_palette u_palette (
        .clk     ( clk      ),
        .rst_n   ( rst_n    ),
        .bus     ( bus      ),
        .cs      ( pal_cs   ),
        .dout    ( pal_dout ),
        .pxl_idx ( pxl_idx  ),
        .blank   ( blank    ),
        .red     ( red      ),
        .green   ( green    ),
        .blue    ( blue     )
    );

    xmen_snd_comm u_snd_comm (
        .clk       ( clk           ),
        .rst_n     ( rst_n         ),
        .bus       ( bus           ),
        .cs        ( snd_cs        ),
        .dout_main ( snd_dout_main ),
        .snd       ( snd           ),
        .snd_dout  ( snd_dout      ),
        .snd_irq   ( snd_irq       ),
        .mute      ( mute          )
    );

endmodule

// File: xmen_game_tb.sv
// ###########################################################################
// Testbench for the game board slice
//  - reads one test per line from the tests file
//  - main CPU on APB, sound CPU on its strobe bus
//  - checks object RAM, scanner port, palette pixels, sound latches, errors
// ###########################################################################
`timescale 1ns/1ps

module xmen_game_tb;
    import xmen_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    apb_req_t    req;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  pxl_idx;
    logic        blank;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;
    logic [12:0] scan_addr;
    logic [15:0] scan_data;
    snd_bus_t    snd;
    logic [7:0]  snd_dout;
    logic        snd_irq;
    logic        mute;

    int seed = 8964;
    int cycle = 0;
    int wd_cycles = 0;
    int limit = 100;
    int errors = 0;
    int n_tests = 0;
    int n_failed = 0;
    bit test_bad;
    // Pixels in flight with due cycle, expected colour and test number
    int          pix_due[$];
    logic [14:0] pix_rgb[$];
    int          pix_num[$];

    xmen_game xmen_game_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        wd_cycles = wd_cycles + 1;
        if (wd_cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic bit compare_value(string name, logic [15:0] exp, logic [15:0] act);
        if (act !== exp) begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic report_test(int num, byte opc, bit bad);
        string verdict;
        verdict = "ok";
        if (bad) begin
            n_failed++;
            verdict = "mismatch";
        end
        $display("test %0d %c %s", num, opc, verdict);
    endtask

    // One falling edge that also retires pixels whose colour is due now
    task automatic tick;
        logic [14:0] exp;
        bit          bad;
        @(negedge clk);
        cycle++;
        while (pix_due.size() > 0 && pix_due[0] == cycle) begin
            exp = pix_rgb.pop_front();
            bad = 1'b0;
            if (compare_value("red", {11'd0, exp[14:10]}, {11'd0, red})) bad = 1'b1;
            if (compare_value("green", {11'd0, exp[9:5]}, {11'd0, green})) bad = 1'b1;
            if (compare_value("blue", {11'd0, exp[4:0]}, {11'd0, blue})) bad = 1'b1;
            report_test(pix_num.pop_front(), "P", bad);
            pix_due.delete(0);
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [16:0] addr,
                                input logic [15:0] data, input logic [1:0] strb,
                                output logic [15:0] rdata, output logic err);
        int n;
        tick;
        psel    = 1'b1;
        penable = 1'b0;
        req     = '{paddr: addr, pwrite: wr, pwdata: data, pstrb: strb};
        tick;
        penable = 1'b1;
        n = 1;
        while (!pready && n < 8) begin
            tick;
            n++;
        end
        if (!pready) begin
            $display("No pready from the bus after %0d access cycles at %0d ns", n, $time);
            errors++;
            test_bad = 1'b1;
        end else if (compare_value("pready cycle", 16'd2, n[15:0])) begin
            test_bad = 1'b1;
        end
        rdata   = prdata;
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_line(string line);
        byte         opc;
        int          v0;
        int          v1;
        int          v2;
        int          v3;
        int          v4;
        int          rnd;
        logic [15:0] data;
        logic [15:0] rdata;
        logic        err;
        void'($sscanf(line, "%c %h %h %h %h %h", opc, v0, v1, v2, v3, v4));
        test_bad = 1'b0;
        n_tests++;
        case (opc)
            "W": begin
                // Lanes outside the strobe carry random filler
                rnd  = $random(seed);
                data = v1[15:0];
                if (!v2[1]) data[15:8] = rnd[15:8];
                if (!v2[0]) data[7:0] = rnd[7:0];
                apb_transfer(1'b1, v0[16:0], data, v2[1:0], rdata, err);
                if (compare_value("pslverr", {15'd0, v3[0]}, {15'd0, err})) test_bad = 1'b1;
            end
            "R": begin
                apb_transfer(1'b0, v0[16:0], 16'h0000, 2'b00, rdata, err);
                if (compare_value("prdata", v1[15:0], rdata)) test_bad = 1'b1;
                if (compare_value("pslverr", {15'd0, v2[0]}, {15'd0, err})) test_bad = 1'b1;
            end
            "P": begin
                tick;
                pxl_idx = v0[7:0];
                blank   = v1[0];
                pix_due.push_back(cycle + PAL_LAT);
                pix_rgb.push_back({v2[4:0], v3[4:0], v4[4:0]});
                pix_num.push_back(n_tests);
            end
            "S": begin
                tick;
                scan_addr = v0[12:0];
                tick;
                if (compare_value("scan_data", v1[15:0], scan_data)) test_bad = 1'b1;
            end
            "D": begin
                tick;
                snd.addr = v0[3:0];
                snd.rd   = 1'b1;
                tick;
                if (compare_value("snd_dout", {8'd0, v1[7:0]}, {8'd0, snd_dout})) test_bad = 1'b1;
                snd.rd = 1'b0;
            end
            "Q": begin
                tick;
                snd.addr = v0[3:0];
                snd.din  = v1[7:0];
                snd.wr   = 1'b1;
                tick;
                snd.wr = 1'b0;
            end
            "I": begin
                tick;
                if (compare_value("snd_irq", {15'd0, v0[0]}, {15'd0, snd_irq})) test_bad = 1'b1;
                if (compare_value("mute", {15'd0, v1[0]}, {15'd0, mute})) test_bad = 1'b1;
            end
            default: begin
                $display("Unknown opcode %c in the tests file", opc);
                errors++;
                test_bad = 1'b1;
            end
        endcase
        // Pixel tests report once their colour comes out
        if (opc != "P") report_test(n_tests, opc, test_bad);
    endtask

    function automatic int count_tests();
        int    fd;
        int    n;
        string line;
        n  = 0;
        fd = $fopen("xmen_tests.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") n++;
            end
            $fclose(fd);
        end
        return n;
    endfunction

    task automatic run_file();
        int    fd;
        string line;
        fd = $fopen("xmen_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open xmen_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") run_line(line);
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        req       = '0;
        pxl_idx   = 8'h00;
        blank     = 1'b0;
        scan_addr = 13'h0000;
        snd       = '0;
        limit     = 20 * count_tests() + 100;
        repeat (4) tick;
        rst_n = 1'b1;
        run_file();
        // Drain the pixel pipeline
        while (pix_due.size() > 0) tick;
        $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: xmen_tests.txt
# W addr data strb err | R addr data err | P idx blank r g b
# S scan_addr data | D addr data | Q addr data | I irq mute   (all values hex)
W 00010 1234 3 0
W 00010 ab56 2 0
W 00010 12cd 1 0
R 00010 abcd 0
S 0004 abcd
W 02a62 c0de 3 0
S 1ea0 c0de
W 0001e 5a5a 3 0
S 0407 5a5a
W 0400a 7c0a 3 0
W 04100 0ebc 3 0
W 041fe c3e1 3 0
R 041fe c3e1 0
P 05 0 1f 00 0a
P 80 0 03 15 1c
P ff 1 00 00 00
P ff 0 10 1f 01
W 08000 0042 1 0
I 1 0
D 0 42
I 0 0
W 08002 0077 1 0
D 1 77
Q 2 c3
R 08004 00c3 0
W 08006 0001 1 0
I 0 1
W 0c010 ffff 3 1
R 0c010 0000 1
R 00010 abcd 0

// File: filelist.f
xmen_pkg.sv
xmen_main_bus.sv
xmen_obj_ram.sv
xmen_palette.sv
xmen_snd_comm.sv
xmen_game.sv
xmen_game_tb.sv

// File: Makefile
# Verilator build and run of the game board testbench
sim:
	verilator --binary --timing --top-module xmen_game_tb -f filelist.f -o xmen_sim
	out=$$(./obj_dir/xmen_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
